/* fetch_frontend.f */
+incdir+.
fetch_pkg.sv
fetch_hazard_unit.sv
branch_predictor.sv
ooo_fetch_stage.sv
fetch_frontend.sv
tb_fetch_frontend.sv

/* Bender.yml */
package:
  name: fetch_frontend

export_include_dirs:
  - .

sources:
  - fetch_pkg.sv
  - fetch_hazard_unit.sv
  - branch_predictor.sv
  - ooo_fetch_stage.sv
  - fetch_frontend.sv
  - target: simulation
    files:
      - tb_fetch_frontend.sv

/* tb_fetch_frontend.sv */
`timescale 1ns/1ns
`include "fetch_params.svh"

module tb_fetch_frontend;

  // roughly 200 cycles of tests, bounded well above that
  localparam int MAX_CYCLES = 2000;
  localparam bit SWAP_BUS = (`BUS_ENDIANNESS == "little");
  localparam fetch_pkg::word_t BOOT = `RESET_PC;

  // one expected latch entry
  typedef struct packed {
    fetch_pkg::word_t pc;
    logic             pred;
  } exp_fetch_t;

  logic                     CLK;
  logic                     nRST;
  logic                     halt;
  logic                     decode_stall;
  logic                     bus_busy;
  fetch_pkg::redirect_t     brj_redirect;
  fetch_pkg::redirect_t     priv_redirect;
  fetch_pkg::btb_update_t   btb_update;
  fetch_pkg::imem_rsp_t     imem_rsp;
  fetch_pkg::imem_req_t     imem_req;
  fetch_pkg::fetch_decode_t fetch_out;
  fetch_pkg::fetch_decode_t last_out;
  fetch_pkg::word_t         mem_word;
  fetch_pkg::word_t         bus_word;

  // 4 KiB window above the boot vector, decoded byte order
  fetch_pkg::word_t imem [1024];
  // btb reference, whole pc kept as tag
  logic             ref_valid [`BTB_ENTRIES];
  fetch_pkg::word_t ref_pc [`BTB_ENTRIES];
  fetch_pkg::word_t ref_tgt [`BTB_ENTRIES];
  logic [1:0]       ref_cnt [`BTB_ENTRIES];
  exp_fetch_t       exp_q [$];
  logic [31:0]      lcg_state;
  int unsigned      cycles = 0;
  // what the dut saw at the last rising edge
  logic             edge_live;
  logic             edge_halt;
  logic             edge_flush;
  logic             edge_fetch;
  fetch_pkg::word_t edge_addr;

  fetch_frontend dut0 (.*);

  // memory model, combinational read
  assign mem_word = imem[imem_req.addr[11:2]];
  // little endian bus delivers bytes reversed
  assign bus_word = SWAP_BUS ? {mem_word[7:0], mem_word[15:8], mem_word[23:16],
                                mem_word[31:24]} : mem_word;
  assign imem_rsp = {bus_word, bus_busy};

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int btb_idx(input fetch_pkg::word_t pc);
    return int'(pc[31:2] % `BTB_ENTRIES);
  endfunction

  // hit with counter in upper half
  function automatic logic ref_taken(input fetch_pkg::word_t pc);
    int i;
    i = btb_idx(pc);
    return ref_valid[i] && (ref_pc[i][31:2] == pc[31:2]) && ref_cnt[i][1];
  endfunction

  task automatic ref_train(input fetch_pkg::btb_update_t u);
    int i;
    i = btb_idx(u.pc);
    if (ref_valid[i] && ref_pc[i] == u.pc) begin
      // saturating at 0 and 3
      ref_cnt[i] = u.taken ? ((ref_cnt[i] == 2'd3) ? 2'd3 : ref_cnt[i] + 2'd1)
                           : ((ref_cnt[i] == 2'd0) ? 2'd0 : ref_cnt[i] - 2'd1);
    end else begin
      ref_cnt[i] = u.taken ? 2'd2 : 2'd1;
    end
    ref_valid[i] = 1'b1;
    ref_pc[i] = u.pc;
    ref_tgt[i] = u.target;
  endtask

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "testbench stopped");
  endtask

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("** Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp));
    end
  endtask

  // n fetches from start along the reference btb path
  task automatic expect_seq(input fetch_pkg::word_t start, input int n);
    fetch_pkg::word_t pc;
    pc = start;
    repeat (n) begin
      exp_q.push_back({pc, ref_taken(pc)});
      pc = ref_taken(pc) ? ref_tgt[btb_idx(pc)] : pc + 32'd4;
    end
  endtask

  // inputs only move on the falling edge, so this is a clean sample
  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      fail_run("timeout: the tests did not finish within the cycle limit");
    end
    edge_live = nRST;
    edge_halt = halt;
    edge_flush = !halt && !bus_busy && (brj_redirect.valid || priv_redirect.valid);
    edge_fetch = !halt && !bus_busy && !decode_stall && !brj_redirect.valid
                 && !priv_redirect.valid;
    // address the bus saw for this edge's fetch
    edge_addr = imem_req.addr;
    if (nRST) begin
      check_value("imem_req.ren", imem_req.ren, !halt);
      check_value("imem_req.byte_en", imem_req.byte_en, 4'hf);
    end
    if (nRST && btb_update.valid) begin
      ref_train(btb_update);
    end
  end

  // latch checks, fetch_out settled since the rising edge
  always @(negedge CLK) begin
    exp_fetch_t e;
    if (edge_live && edge_halt) begin
      check_value("fetch_out.token", fetch_out.token, 1'b0);
      check_value("fetch_out.pc", fetch_out.pc, 32'd0);
      check_value("fetch_out.pc4", fetch_out.pc4, 32'd0);
      check_value("fetch_out.prediction", fetch_out.prediction, 1'b0);
    end else if (edge_live && edge_flush) begin
      check_value("fetch_out.token", fetch_out.token, 1'b0);
      check_value("fetch_out.instr", fetch_out.instr, 32'd0);
      check_value("fetch_out.prediction", fetch_out.prediction, 1'b0);
      check_value("fetch_out.mal_insn", fetch_out.mal_insn, 1'b0);
    end else if (edge_live && edge_fetch) begin
      check_value("fetch_out.token", fetch_out.token, 1'b1);
      check_value("fetch_out.fault_insn", fetch_out.fault_insn, 1'b0);
      // free running fetch between tests goes unchecked
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        check_value("imem_req.addr", edge_addr, e.pc);
        check_value("fetch_out.pc", fetch_out.pc, e.pc);
        check_value("fetch_out.pc4", fetch_out.pc4, e.pc + 32'd4);
        check_value("fetch_out.instr", fetch_out.instr, imem[e.pc[11:2]]);
        check_value("fetch_out.prediction", fetch_out.prediction, e.pred);
        check_value("fetch_out.mal_insn", fetch_out.mal_insn, e.pc[1:0] != 2'b00);
      end
    end else if (edge_live) begin
      // back-pressure holds the whole latch
      check_value("fetch_out", fetch_out, last_out);
    end
    last_out = fetch_out;
  end

  task automatic run_until_drained(input bit noisy);
    while (exp_q.size() != 0) begin
      @(negedge CLK);
      lcg_state = lcg_next(lcg_state);
      bus_busy = noisy && (lcg_state[31:30] == 2'b00);
      decode_stall = noisy && (lcg_state[29:28] == 2'b00);
      // queue pops land on the falling edge, look again after the rise
      @(posedge CLK);
    end
  endtask

  // one-cycle redirect on an idle bus, then queue the new path
  task automatic redirect(input fetch_pkg::redirect_t brj, input fetch_pkg::redirect_t priv,
                          input fetch_pkg::word_t start, input int n);
    @(negedge CLK);
    bus_busy = 1'b0;
    decode_stall = 1'b0;
    brj_redirect = brj;
    priv_redirect = priv;
    @(posedge CLK);
    expect_seq(start, n);
    @(negedge CLK);
    brj_redirect = '0;
    priv_redirect = '0;
  endtask

  task automatic train(input fetch_pkg::word_t pc, input fetch_pkg::word_t tgt,
                       input logic taken);
    @(negedge CLK);
    btb_update = {1'b1, pc, tgt, taken};
    @(negedge CLK);
    btb_update = '0;
  endtask

  task automatic test_reset_seq();
    repeat (2) @(negedge CLK);
    expect_seq(BOOT, 12);
    nRST = 1'b1;
    check_value("fetch_out.token", fetch_out.token, 1'b0);
    run_until_drained(1'b0);
  endtask

  task automatic test_backpressure();
    redirect({1'b1, BOOT + 32'h500}, '0, BOOT + 32'h500, 24);
    run_until_drained(1'b1);
  endtask

  task automatic test_redirects();
    redirect({1'b1, BOOT + 32'h200}, '0, BOOT + 32'h200, 4);
    run_until_drained(1'b0);
    // privileged target beats the branch target
    redirect({1'b1, BOOT + 32'h600}, {1'b1, BOOT + 32'h280}, BOOT + 32'h280, 4);
    run_until_drained(1'b0);
    // misaligned path, mal_insn on every fetch
    redirect({1'b1, BOOT + 32'h342}, '0, BOOT + 32'h342, 3);
    run_until_drained(1'b0);
  endtask

  task automatic test_prediction();
    train(BOOT + 32'h100, BOOT + 32'h400, 1'b1);
    redirect({1'b1, BOOT + 32'hf8}, '0, BOOT + 32'hf8, 5);
    run_until_drained(1'b0);
    // counter 2 down to 0
    train(BOOT + 32'h100, BOOT + 32'h400, 1'b0);
    train(BOOT + 32'h100, BOOT + 32'h400, 1'b0);
    redirect({1'b1, BOOT + 32'hfc}, '0, BOOT + 32'hfc, 4);
    run_until_drained(1'b0);
  endtask

  task automatic test_halt();
    train(BOOT + 32'h8, BOOT + 32'h300, 1'b1);
    @(negedge CLK);
    bus_busy = 1'b0;
    decode_stall = 1'b0;
    halt = 1'b1;
    repeat (3) @(posedge CLK);
    // btb entry survives halt
    expect_seq(BOOT, 5);
    @(negedge CLK);
    halt = 1'b0;
    run_until_drained(1'b1);
  endtask

  initial begin
    fetch_pkg::word_t a;
    nRST = 1'b0;
    halt = 1'b0;
    decode_stall = 1'b0;
    bus_busy = 1'b0;
    brj_redirect = '0;
    priv_redirect = '0;
    btb_update = '0;
    lcg_state = 32'h211a11f4;
    for (int i = 0; i < 1024; i++) begin
      a = BOOT + 32'(i * 4);
      imem[i] = a * 32'h9e3779b1 ^ {a[15:0], a[31:16]};
    end
    for (int i = 0; i < `BTB_ENTRIES; i++) begin
      ref_valid[i] = 1'b0;
    end
    test_reset_seq();
    test_backpressure();
    test_redirects();
    test_prediction();
    test_halt();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* fetch_frontend.sv */
`timescale 1ns/1ns

module fetch_frontend (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     halt,
  input  logic                     decode_stall,
  input  fetch_pkg::redirect_t     brj_redirect,
  input  fetch_pkg::redirect_t     priv_redirect,
  input  fetch_pkg::btb_update_t   btb_update,
  input  fetch_pkg::imem_rsp_t     imem_rsp,
  output fetch_pkg::imem_req_t     imem_req,
  output fetch_pkg::fetch_decode_t fetch_out
);

  // pc from fetch into the btb
  fetch_pkg::word_t        current_pc;
  // same-cycle btb answer
  fetch_pkg::predict_t     predict;
  // hazard decisions into fetch
  fetch_pkg::hazard_ctrl_t hazard;

  ooo_fetch_stage fetch0 (
    .CLK          (CLK),
    .nRST         (nRST),
    .halt         (halt),
    .hazard       (hazard),
    .brj_redirect (brj_redirect),
    .priv_redirect(priv_redirect),
    .predict      (predict),
    .current_pc   (current_pc),
    .imem_req     (imem_req),
    .imem_rsp     (imem_rsp),
    .fetch_out    (fetch_out)
  );

  branch_predictor btb0 (
    .CLK       (CLK),
    .nRST      (nRST),
    .current_pc(current_pc),
    .predict   (predict),
    .btb_update(btb_update)
  );

  fetch_hazard_unit hazard0 (
    .imem_busy          (imem_rsp.busy),
    .decode_stall       (decode_stall),
    .brj_redirect_valid (brj_redirect.valid),
    .priv_redirect_valid(priv_redirect.valid),
    .hazard             (hazard)
  );

endmodule

/* ooo_fetch_stage.sv */
`timescale 1ns/1ns
`include "fetch_params.svh"

module ooo_fetch_stage (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     halt,
  input  fetch_pkg::hazard_ctrl_t  hazard,
  input  fetch_pkg::redirect_t     brj_redirect,
  input  fetch_pkg::redirect_t     priv_redirect,
  input  fetch_pkg::predict_t      predict,
  output fetch_pkg::word_t         current_pc,
  output fetch_pkg::imem_req_t     imem_req,
  input  fetch_pkg::imem_rsp_t     imem_rsp,
  output fetch_pkg::fetch_decode_t fetch_out
);

  localparam fetch_pkg::word_t RESET_PC = `RESET_PC;
  // string compare on the define, resolved at elaboration
  localparam bit SWAP_BYTES = (`BUS_ENDIANNESS == "little");

  fetch_pkg::word_t pc_q;
  fetch_pkg::word_t pc4;
  fetch_pkg::word_t next_pc;
  fetch_pkg::word_t instr;
  logic             mal_addr;
  logic             pc_load;

  assign pc4        = pc_q + 32'd4;
  assign current_pc = pc_q;
  // only word aligned fetches are legal
  assign mal_addr   = (pc_q[1:0] != 2'b00);

  // bus request straight off the pc
  assign imem_req.addr    = pc_q;
  assign imem_req.ren     = ~halt;
  assign imem_req.byte_en = 4'b1111;

  // endian handling
  always_comb begin
    if (SWAP_BYTES) begin
      instr = {imem_rsp.rdata[7:0], imem_rsp.rdata[15:8],
               imem_rsp.rdata[23:16], imem_rsp.rdata[31:24]};
    end else begin
      instr = imem_rsp.rdata;
    end
  end

  // next pc, privileged first, then execute, then btb
  always_comb begin
    if (priv_redirect.valid) begin
      next_pc = priv_redirect.target;
    end else if (brj_redirect.valid) begin
      next_pc = brj_redirect.target;
    end else if (predict.predict_taken) begin
      next_pc = predict.target_addr;
    end else begin
      next_pc = pc4;
    end
  end

  // privileged redirect moves the pc even under back-pressure
  assign pc_load = (hazard.pc_en & ~hazard.stall) | priv_redirect.valid;

  // program counter
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc_q <= RESET_PC;
    end else if (halt) begin
      pc_q <= RESET_PC;
    end else if (pc_load) begin
      pc_q <= next_pc;
    end
  end

  // fetch/decode latch
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      fetch_out <= '0;
    end else if (halt) begin
      // instr left as is, token already marks it dead
      fetch_out.token      <= 1'b0;
      fetch_out.pc         <= '0;
      fetch_out.pc4        <= '0;
      fetch_out.prediction <= 1'b0;
      fetch_out.mal_insn   <= 1'b0;
      fetch_out.fault_insn <= 1'b0;
    end else if (hazard.if_id_flush && hazard.pc_en) begin
      // kill the wrong-path word
      fetch_out.token      <= 1'b0;
      fetch_out.instr      <= '0;
      fetch_out.prediction <= 1'b0;
      fetch_out.mal_insn   <= 1'b0;
      fetch_out.fault_insn <= 1'b0;
    end else if (hazard.pc_en && !hazard.stall) begin
      fetch_out.token      <= 1'b1;
      fetch_out.pc         <= pc_q;
      fetch_out.pc4        <= pc4;
      fetch_out.instr      <= instr;
      fetch_out.prediction <= predict.predict_taken;
      fetch_out.mal_insn   <= mal_addr;
      // no access faults from this bus
      fetch_out.fault_insn <= 1'b0;
    end
  end

  // halt always lands fetch back on the boot vector
  a_halt_reset_pc : assert property (
    @(posedge CLK) disable iff (!nRST)
    halt |=> (current_pc == RESET_PC)
  );

  // a busy bus never yields a new latch entry
  a_no_token_while_busy : assert property (
    @(posedge CLK) disable iff (!nRST)
    imem_rsp.busy |=> !$rose(fetch_out.token)
  );

endmodule

/* branch_predictor.sv */
`timescale 1ns/1ns
`include "fetch_params.svh"

module branch_predictor (
  input  logic                   CLK,
  input  logic                   nRST,
  input  fetch_pkg::word_t       current_pc,
  output fetch_pkg::predict_t    predict,
  input  fetch_pkg::btb_update_t btb_update
);

  localparam int ENTRIES    = `BTB_ENTRIES;
  localparam int INDEX_BITS = $clog2(ENTRIES);
  // pc bits above the index, bits 1:0 dropped
  localparam int TAG_BITS   = 30 - INDEX_BITS;

  // one btb line, valid bit kept apart for reset
  typedef struct packed {
    logic [TAG_BITS-1:0] tag;
    fetch_pkg::word_t    target;
    logic [1:0]          cnt;
  } btb_entry_t;

  btb_entry_t           btb_q [ENTRIES];
  logic [ENTRIES-1:0]   valid_q;

  logic [INDEX_BITS-1:0] rd_idx;
  logic [TAG_BITS-1:0]   rd_tag;
  logic                  rd_hit;
  logic [INDEX_BITS-1:0] wr_idx;
  logic [TAG_BITS-1:0]   wr_tag;
  logic                  wr_hit;
  logic [1:0]            wr_cnt;

  // lookup side
  assign rd_idx = current_pc[INDEX_BITS+1:2];
  assign rd_tag = current_pc[31:INDEX_BITS+2];
  assign rd_hit = valid_q[rd_idx] && (btb_q[rd_idx].tag == rd_tag);

  // taken only on a hit with counter in the upper half
  assign predict.predict_taken = rd_hit && btb_q[rd_idx].cnt[1];
  assign predict.target_addr   = btb_q[rd_idx].target;

  // update side
  assign wr_idx = btb_update.pc[INDEX_BITS+1:2];
  assign wr_tag = btb_update.pc[31:INDEX_BITS+2];
  assign wr_hit = valid_q[wr_idx] && (btb_q[wr_idx].tag == wr_tag);

  // new counter value
  always_comb begin
    if (!wr_hit) begin
      // fresh entry starts weakly biased
      wr_cnt = btb_update.taken ? 2'd2 : 2'd1;
    end else if (btb_update.taken) begin
      wr_cnt = (btb_q[wr_idx].cnt == 2'd3) ? 2'd3 : btb_q[wr_idx].cnt + 2'd1;
    end else begin
      wr_cnt = (btb_q[wr_idx].cnt == 2'd0) ? 2'd0 : btb_q[wr_idx].cnt - 2'd1;
    end
  end

  // valid bits
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_q <= '0;
    end else if (btb_update.valid) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // table body, written on the update strobe
  always_ff @(posedge CLK) begin
    if (btb_update.valid) begin
      btb_q[wr_idx].tag    <= wr_tag;
      btb_q[wr_idx].target <= btb_update.target;
      btb_q[wr_idx].cnt    <= wr_cnt;
    end
  end

  // execute only trains on word aligned branch pcs
  a_update_aligned : assert property (
    @(posedge CLK) disable iff (!nRST)
    btb_update.valid |-> (btb_update.pc[1:0] == 2'b00)
  );

endmodule

/* fetch_hazard_unit.sv */
`timescale 1ns/1ns

module fetch_hazard_unit (
  input  logic                    imem_busy,
  input  logic                    decode_stall,
  input  logic                    brj_redirect_valid,
  input  logic                    priv_redirect_valid,
  output fetch_pkg::hazard_ctrl_t hazard
);

  logic any_redirect;

  // either redirect kills the word in flight
  assign any_redirect = brj_redirect_valid | priv_redirect_valid;

  // pc may advance only once the bus has answered
  assign hazard.pc_en = ~imem_busy;

  // decode back-pressure passes through as the stall
  assign hazard.stall = decode_stall;

  // latch flush request, fetch qualifies it with pc_en
  assign hazard.if_id_flush = any_redirect;

  // both redirects at once on a busy bus would lose the branch target
  always_comb begin
    a_redirect_collision : assert final (
      !(imem_busy && priv_redirect_valid && brj_redirect_valid)
    ) else $error("privileged and branch redirect together while bus busy");
  end

endmodule

/* fetch_pkg.sv */
package fetch_pkg;

  // one machine word
  typedef logic [31:0] word_t;

  // instruction bus request, read only
  typedef struct packed {
    word_t      addr;
    logic       ren;
    logic [3:0] byte_en;
  } imem_req_t;

  // instruction bus response
  // rdata valid in any cycle with busy low
  typedef struct packed {
    word_t rdata;
    logic  busy;
  } imem_rsp_t;

  // fetch/decode latch contents
  typedef struct packed {
    logic  token;
    word_t pc;
    word_t pc4;
    word_t instr;
    logic  prediction;
    logic  mal_insn;
    logic  fault_insn;
  } fetch_decode_t;

  // redirect request, branch/jump or privileged
  typedef struct packed {
    logic  valid;
    word_t target;
  } redirect_t;

  // predictor answer for the current pc
  typedef struct packed {
    logic  predict_taken;
    word_t target_addr;
  } predict_t;

  // training strobe from execute
  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t target;
    logic  taken;
  } btb_update_t;

  // hazard unit decisions for fetch
  typedef struct packed {
    logic pc_en;
    logic stall;
    logic if_id_flush;
  } hazard_ctrl_t;

endpackage

/* fetch_params.svh */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// boot vector, also where halt sends fetch
`define RESET_PC 32'h80000000

// btb depth, must be a power of two
`define BTB_ENTRIES 16

// byte order of the instruction bus
// "little" swaps bytes on the way in, "big" passes rdata through
`define BUS_ENDIANNESS "little"

`endif
